// ==== logic/cache_geom_pkg.sv ====
/*
 * Cache geometry
 * Sizes of the 4-way, 16-set cache with 4-word lines of 32 bits, and the
 * index, tag, way and data types built on them.
 */
`default_nettype none

package cache_geom_pkg;

    localparam int unsigned WAYS          = 4;
    localparam int unsigned SETS          = 16;
    localparam int unsigned LINE_WORDS    = 4;
    localparam int unsigned WORD_BITS     = 32;
    localparam int unsigned TAG_BITS      = 8;
    localparam int unsigned SET_BITS      = $clog2(SETS);
    localparam int unsigned WORD_IDX_BITS = $clog2(LINE_WORDS);
    localparam int unsigned BE_BITS       = WORD_BITS / 8;
    localparam int unsigned DATA_DEPTH    = SETS * LINE_WORDS;
    localparam int unsigned PLRU_BITS     = WAYS - 1;
    localparam int unsigned NLINE_BITS    = TAG_BITS + SET_BITS;

    typedef logic [SET_BITS-1:0]           set_t;
    typedef logic [TAG_BITS-1:0]           tag_t;
    typedef logic [WORD_IDX_BITS-1:0]      word_idx_t;
    typedef logic [WAYS-1:0]               way_vec_t;
    typedef logic [WORD_BITS-1:0]          data_word_t;
    typedef logic [BE_BITS-1:0]            be_t;
    typedef logic [$clog2(DATA_DEPTH)-1:0] data_addr_t;

    // Line number split, tag in the upper bits
    typedef struct packed {
        tag_t tag;
        set_t set_idx;
    } nline_fields_t;

    typedef union packed {
        logic [NLINE_BITS-1:0] raw;
        nline_fields_t         part;
    } nline_u;

endpackage

`default_nettype wire

// ==== logic/cache_dir_pkg.sv ====
/*
 * Cache directory definitions
 * Layout of one directory entry and the operations the directory serves.
 */
`default_nettype none

package cache_dir_pkg;

    import cache_geom_pkg::*;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } dir_entry_t;

    localparam int unsigned DIR_BITS = $bits(dir_entry_t);

    // One operation per cycle, in priority order below init
    typedef enum logic [2:0] {
        DIR_IDLE,
        DIR_INIT,
        DIR_MATCH,
        DIR_REFILL,
        DIR_INVAL_CHECK,
        DIR_INVAL_WRITE
    } dir_op_e;

endpackage

`default_nettype wire

// ==== logic/sp_ram.sv ====
/*
 * Single-port synchronous RAM
 * Byte-enabled write, registered read. The read port keeps its last
 * value while the RAM is not read.
 */
`timescale 1ns/10ps
`default_nettype none

module sp_ram #(
    parameter int unsigned WIDTH = 32,
    parameter int unsigned DEPTH = 64
) (
    input  logic                     clk_i,
    input  logic                     cs_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  logic [WIDTH-1:0]         wdata_i,
    input  logic [(WIDTH+7)/8-1:0]   be_i,
    output logic [WIDTH-1:0]         rdata_o
);

    logic [WIDTH-1:0] mem_q [DEPTH];

    always_ff @(posedge clk_i) begin
        if (cs_i) begin
            if (we_i) begin
                // Last byte lane may be partial when WIDTH is not a multiple of 8
                for (int i = 0; i < WIDTH; i++) begin
                    if (be_i[i / 8]) begin
                        mem_q[addr_i][i] <= wdata_i[i];
                    end
                end
            end else begin
                rdata_o <= mem_q[addr_i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/dir_ctrl.sv ====
/*
 * Cache directory controller
 * Clears the directory after reset, then serves tag lookups, refills and
 * two-step invalidations on one RAM per way. Hits are computed from the
 * registered RAM outputs one cycle after the read.
 */
`timescale 1ns/10ps
`default_nettype none

module dir_ctrl import cache_geom_pkg::*, cache_dir_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    output logic     ready_o,
    input  logic     match_i,
    input  set_t     match_set_i,
    input  tag_t     match_tag_i,
    input  logic     refill_i,
    input  set_t     refill_set_i,
    input  way_vec_t refill_way_i,
    input  tag_t     refill_tag_i,
    input  logic     inval_check_i,
    input  logic     inval_write_i,
    input  nline_u   inval_nline_i,
    output way_vec_t hit_way_o,
    output logic     inval_hit_o,
    output set_t     lookup_set_o,
    output way_vec_t valid_o
);

    logic                  init_done_q;
    set_t                  init_set_q;
    dir_op_e               op;
    way_vec_t              dir_cs;
    way_vec_t              dir_we;
    set_t                  dir_addr;
    dir_entry_t            dir_wentry;
    dir_entry_t [WAYS-1:0] dir_rentry;
    way_vec_t              tag_hit;
    way_vec_t              inval_way;
    logic                  rd_match_q;
    logic                  rd_inval_q;
    set_t                  lookup_set_q;
    tag_t                  lookup_tag_q;

    // Init walks every set once, writing invalid entries
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            init_done_q <= 1'b0;
            init_set_q  <= '0;
        end else if (!init_done_q) begin
            init_done_q <= (init_set_q == set_t'(SETS - 1));
            init_set_q  <= init_set_q + 1'b1;
        end
    end

    assign ready_o = init_done_q;

    always_comb begin
        if (!init_done_q)       op = DIR_INIT;
        else if (match_i)       op = DIR_MATCH;
        else if (refill_i)      op = DIR_REFILL;
        else if (inval_check_i) op = DIR_INVAL_CHECK;
        else if (inval_write_i) op = DIR_INVAL_WRITE;
        else                    op = DIR_IDLE;
    end

    always_comb begin
        dir_cs     = '0;
        dir_we     = '0;
        dir_addr   = lookup_set_q;
        dir_wentry = '0;
        case (op)
            DIR_INIT: begin
                dir_cs   = '1;
                dir_we   = '1;
                dir_addr = init_set_q;
            end
            DIR_MATCH: begin
                dir_cs   = '1;
                dir_addr = match_set_i;
            end
            DIR_REFILL: begin
                dir_cs           = refill_way_i;
                dir_we           = refill_way_i;
                dir_addr         = refill_set_i;
                dir_wentry.valid = 1'b1;
                dir_wentry.tag   = refill_tag_i;
            end
            DIR_INVAL_CHECK: begin
                dir_cs   = '1;
                dir_addr = inval_nline_i.part.set_idx;
            end
            DIR_INVAL_WRITE: begin
                // Clear only the ways that hit at the check
                dir_cs   = inval_way;
                dir_we   = inval_way;
                dir_addr = inval_nline_i.part.set_idx;
            end
            default: ;
        endcase
    end

    for (genvar w = 0; w < WAYS; w++) begin : gen_dir_ram
        sp_ram #(
            .WIDTH (DIR_BITS),
            .DEPTH (SETS)
        ) dir_ram_i (
            .clk_i   (clk_i),
            .cs_i    (dir_cs[w]),
            .we_i    (dir_we[w]),
            .addr_i  (dir_addr),
            .wdata_i (dir_wentry),
            .be_i    ('1),
            .rdata_o (dir_rentry[w])
        );

        assign tag_hit[w] = dir_rentry[w].valid & (dir_rentry[w].tag == lookup_tag_q);
        assign valid_o[w] = (rd_match_q | rd_inval_q) & dir_rentry[w].valid;
    end

    // Kind of the last read, so each hit output answers its own request
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_match_q   <= 1'b0;
            rd_inval_q   <= 1'b0;
            lookup_set_q <= '0;
        end else if (op == DIR_MATCH || op == DIR_INVAL_CHECK) begin
            rd_match_q   <= (op == DIR_MATCH);
            rd_inval_q   <= (op == DIR_INVAL_CHECK);
            lookup_set_q <= dir_addr;
        end
    end

    always_ff @(posedge clk_i) begin
        if (op == DIR_MATCH) begin
            lookup_tag_q <= match_tag_i;
        end else if (op == DIR_INVAL_CHECK) begin
            lookup_tag_q <= inval_nline_i.part.tag;
        end
    end

    assign inval_way    = rd_inval_q ? tag_hit : '0;
    assign hit_way_o    = rd_match_q ? tag_hit : '0;
    assign inval_hit_o  = |inval_way;
    assign lookup_set_o = lookup_set_q;

    dir_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({match_i, refill_i, inval_check_i, inval_write_i}))
        else $error("dir_ctrl: concurrent directory requests");

    dir_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !ready_o |-> !(match_i | refill_i | inval_check_i | inval_write_i))
        else $error("dir_ctrl: directory request before ready");

    // Write must follow its check on the same line
    dir_inval_seq_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        inval_write_i |-> $past(inval_check_i) && (inval_nline_i.raw == $past(inval_nline_i.raw)))
        else $error("dir_ctrl: invalidation write without matching check");

endmodule

`default_nettype wire

// ==== logic/plru_victim.sv ====
/*
 * Tree pseudo-LRU and victim select
 * Three tree bits per set, updated on hits and refills. The victim is the
 * lowest invalid way, or the way the tree points at when the set is full.
 */
`timescale 1ns/10ps
`default_nettype none

module plru_victim import cache_geom_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     updt_i,
    input  set_t     updt_set_i,
    input  way_vec_t updt_way_i,
    input  logic     repl_i,
    input  set_t     repl_set_i,
    input  way_vec_t repl_way_i,
    input  way_vec_t valid_i,
    output way_vec_t victim_way_o
);

    // Bit 0 root, bit 1 node of ways 0/1, bit 2 node of ways 2/3
    logic [PLRU_BITS-1:0] plru_q [SETS];
    logic [PLRU_BITS-1:0] victim_tree;
    logic                 found;

    // Point the tree away from the accessed way
    function automatic logic [PLRU_BITS-1:0] plru_touch(
        input logic [PLRU_BITS-1:0] tree,
        input way_vec_t             way
    );
        logic [PLRU_BITS-1:0] next;
        next = tree;
        if (way[0] | way[1]) begin
            next[0] = 1'b1;
            next[1] = way[0];
        end else if (way[2] | way[3]) begin
            next[0] = 1'b0;
            next[2] = way[2];
        end
        return next;
    endfunction

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int s = 0; s < SETS; s++) begin
                plru_q[s] <= '0;
            end
        end else begin
            if (updt_i) begin
                plru_q[updt_set_i] <= plru_touch(plru_q[updt_set_i], updt_way_i);
            end
            // Refill wins when both touch the same set
            if (repl_i) begin
                plru_q[repl_set_i] <= plru_touch(plru_q[repl_set_i], repl_way_i);
            end
        end
    end

    assign victim_tree = plru_q[updt_set_i];

    always_comb begin
        victim_way_o = '0;
        found        = 1'b0;
        for (int i = 0; i < WAYS; i++) begin
            if (!valid_i[i] && !found) begin
                victim_way_o[i] = 1'b1;
                found           = 1'b1;
            end
        end
        if (!found) begin
            if (!victim_tree[0]) begin
                victim_way_o[{1'b0, victim_tree[1]}] = 1'b1;
            end else begin
                victim_way_o[{1'b1, victim_tree[2]}] = 1'b1;
            end
        end
    end

    victim_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot(victim_way_o))
        else $error("plru_victim: victim way is not one-hot");

endmodule

`default_nettype wire

// ==== logic/data_ctrl.sv ====
/*
 * Cache data controller
 * One word-wide RAM per way, addressed by set and word. Reads access all
 * ways and the hit way is selected a cycle later.
 */
`timescale 1ns/10ps
`default_nettype none

module data_ctrl import cache_geom_pkg::*; (
    input  logic       clk_i,
    input  logic       read_i,
    input  set_t       read_set_i,
    input  word_idx_t  read_word_i,
    input  way_vec_t   hit_way_i,
    output data_word_t read_data_o,
    input  logic       write_i,
    input  set_t       write_set_i,
    input  word_idx_t  write_word_i,
    input  way_vec_t   write_way_i,
    input  data_word_t write_data_i,
    input  be_t        write_be_i,
    input  logic       refill_i,
    input  set_t       refill_set_i,
    input  word_idx_t  refill_word_i,
    input  way_vec_t   refill_way_i,
    input  data_word_t refill_data_i
);

    way_vec_t              ram_cs;
    way_vec_t              ram_we;
    data_addr_t            ram_addr;
    data_word_t            ram_wdata;
    be_t                   ram_be;
    data_word_t [WAYS-1:0] ram_rdata;

    always_comb begin
        ram_cs    = '0;
        ram_we    = '0;
        ram_addr  = '0;
        ram_wdata = '0;
        ram_be    = '0;
        if (refill_i) begin
            ram_cs    = refill_way_i;
            ram_we    = refill_way_i;
            ram_addr  = {refill_set_i, refill_word_i};
            ram_wdata = refill_data_i;
            ram_be    = '1;
        end else if (write_i) begin
            ram_cs    = write_way_i;
            ram_we    = write_way_i;
            ram_addr  = {write_set_i, write_word_i};
            ram_wdata = write_data_i;
            ram_be    = write_be_i;
        end else if (read_i) begin
            // Way is not known yet, read them all
            ram_cs    = '1;
            ram_addr  = {read_set_i, read_word_i};
        end
    end

    for (genvar w = 0; w < WAYS; w++) begin : gen_data_ram
        sp_ram #(
            .WIDTH (WORD_BITS),
            .DEPTH (DATA_DEPTH)
        ) data_ram_i (
            .clk_i   (clk_i),
            .cs_i    (ram_cs[w]),
            .we_i    (ram_we[w]),
            .addr_i  (ram_addr),
            .wdata_i (ram_wdata),
            .be_i    (ram_be),
            .rdata_o (ram_rdata[w])
        );
    end

    // One-hot AND-OR mux, zero on a miss
    always_comb begin
        read_data_o = '0;
        for (int w = 0; w < WAYS; w++) begin
            read_data_o = read_data_o | (ram_rdata[w] & {WORD_BITS{hit_way_i[w]}});
        end
    end

    data_onehot_a: assert property (@(posedge clk_i)
        $onehot0({read_i, write_i, refill_i}))
        else $error("data_ctrl: concurrent data requests");

endmodule

`default_nettype wire

// ==== logic/cache_memctrl.sv ====
/*
 * Cache memory controller top
 * Connects the directory, the pseudo-LRU victim select and the data arrays.
 */
`timescale 1ns/10ps
`default_nettype none

module cache_memctrl import cache_geom_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    output logic       ready_o,
    input  logic       dir_match_i,
    input  set_t       dir_match_set_i,
    input  tag_t       dir_match_tag_i,
    input  logic       dir_update_lru_i,
    output way_vec_t   dir_hit_way_o,
    input  logic       dir_refill_i,
    input  set_t       dir_refill_set_i,
    input  way_vec_t   dir_refill_way_i,
    input  tag_t       dir_refill_tag_i,
    input  logic       dir_refill_updt_plru_i,
    output way_vec_t   dir_victim_way_o,
    input  logic       dir_inval_check_i,
    input  nline_u     dir_inval_nline_i,
    input  logic       dir_inval_write_i,
    output logic       dir_inval_hit_o,
    input  logic       data_read_i,
    input  set_t       data_read_set_i,
    input  word_idx_t  data_read_word_i,
    output data_word_t data_read_data_o,
    input  logic       data_write_i,
    input  set_t       data_write_set_i,
    input  word_idx_t  data_write_word_i,
    input  way_vec_t   data_write_way_i,
    input  data_word_t data_write_data_i,
    input  be_t        data_write_be_i,
    input  logic       data_refill_i,
    input  set_t       data_refill_set_i,
    input  way_vec_t   data_refill_way_i,
    input  word_idx_t  data_refill_word_i,
    input  data_word_t data_refill_data_i
);

    way_vec_t hit_way;
    set_t     lookup_set;
    way_vec_t dir_valid;

    dir_ctrl dir_ctrl_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .ready_o       (ready_o),
        .match_i       (dir_match_i),
        .match_set_i   (dir_match_set_i),
        .match_tag_i   (dir_match_tag_i),
        .refill_i      (dir_refill_i),
        .refill_set_i  (dir_refill_set_i),
        .refill_way_i  (dir_refill_way_i),
        .refill_tag_i  (dir_refill_tag_i),
        .inval_check_i (dir_inval_check_i),
        .inval_write_i (dir_inval_write_i),
        .inval_nline_i (dir_inval_nline_i),
        .hit_way_o     (hit_way),
        .inval_hit_o   (dir_inval_hit_o),
        .lookup_set_o  (lookup_set),
        .valid_o       (dir_valid)
    );

    assign dir_hit_way_o = hit_way;

    plru_victim plru_victim_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .updt_i       (dir_update_lru_i),
        .updt_set_i   (lookup_set),
        .updt_way_i   (hit_way),
        .repl_i       (dir_refill_i & dir_refill_updt_plru_i),
        .repl_set_i   (dir_refill_set_i),
        .repl_way_i   (dir_refill_way_i),
        .valid_i      (dir_valid),
        .victim_way_o (dir_victim_way_o)
    );

    data_ctrl data_ctrl_i (
        .clk_i         (clk_i),
        .read_i        (data_read_i),
        .read_set_i    (data_read_set_i),
        .read_word_i   (data_read_word_i),
        .hit_way_i     (hit_way),
        .read_data_o   (data_read_data_o),
        .write_i       (data_write_i),
        .write_set_i   (data_write_set_i),
        .write_word_i  (data_write_word_i),
        .write_way_i   (data_write_way_i),
        .write_data_i  (data_write_data_i),
        .write_be_i    (data_write_be_i),
        .refill_i      (data_refill_i),
        .refill_set_i  (data_refill_set_i),
        .refill_word_i (data_refill_word_i),
        .refill_way_i  (data_refill_way_i),
        .refill_data_i (data_refill_data_i)
    );

endmodule

`default_nettype wire

// ==== test/clk_rst_gen.sv ====
/*
 * Testbench clock and reset
 * Free-running clock and an active-low reset held for a fixed number of cycles.
 */
`timescale 1ns/10ps
`default_nettype none

module clk_rst_gen #(
    parameter int unsigned HALF_PERIOD  = 4,
    parameter int unsigned RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // Released on a rising edge, in step with the stimulus
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== test/tb_cache_memctrl.sv ====
/*
 * Testbench for the cache memory controller
 * Directed tests of directory init, lookup, refill, invalidation, victim
 * selection and the data arrays, with a watchdog and a closing summary.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_cache_memctrl import cache_geom_pkg::*; ();

    localparam int unsigned RESET_CYCLES   = 16;
    // Cycle budget of each test in order, init first
    localparam int unsigned TEST_CYCLES    = RESET_CYCLES + SETS + 1 + 3 * SETS
                                             + 8 + 23 + 5 + 9 + 23;
    localparam int unsigned TIMEOUT_CYCLES = 2 * TEST_CYCLES + 50;

    localparam set_t     SET_A = 4'd5;
    localparam set_t     SET_V = 4'd9;
    localparam tag_t     TAG_A = 8'h3c;
    localparam tag_t     TAG_B = 8'hc5;
    localparam way_vec_t WAY_2 = 4'b0100;

    integer      seed;
    int unsigned checks;
    int unsigned errors;
    data_word_t  line_words [LINE_WORDS];

    logic       clk_i;
    logic       rst_ni;
    logic       ready_o;
    logic       dir_match_i;
    set_t       dir_match_set_i;
    tag_t       dir_match_tag_i;
    logic       dir_update_lru_i;
    way_vec_t   dir_hit_way_o;
    logic       dir_refill_i;
    set_t       dir_refill_set_i;
    way_vec_t   dir_refill_way_i;
    tag_t       dir_refill_tag_i;
    logic       dir_refill_updt_plru_i;
    way_vec_t   dir_victim_way_o;
    logic       dir_inval_check_i;
    nline_u     dir_inval_nline_i;
    logic       dir_inval_write_i;
    logic       dir_inval_hit_o;
    logic       data_read_i;
    set_t       data_read_set_i;
    word_idx_t  data_read_word_i;
    data_word_t data_read_data_o;
    logic       data_write_i;
    set_t       data_write_set_i;
    word_idx_t  data_write_word_i;
    way_vec_t   data_write_way_i;
    data_word_t data_write_data_i;
    be_t        data_write_be_i;
    logic       data_refill_i;
    set_t       data_refill_set_i;
    way_vec_t   data_refill_way_i;
    word_idx_t  data_refill_word_i;
    data_word_t data_refill_data_i;

    clk_rst_gen #(
        .HALF_PERIOD  (4),
        .RESET_CYCLES (RESET_CYCLES)
    ) clk_rst_gen_i (
        .clk_o  (clk_i),
        .rst_no (rst_ni)
    );

    cache_memctrl cache_memctrl_i (.*);

    task automatic check_way(input string name, input way_vec_t exp, input way_vec_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input data_word_t exp, input data_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    // Enabled bytes come from the new word, the rest stay
    function automatic data_word_t merge_bytes(input data_word_t old_w, input data_word_t new_w,
                                               input be_t be);
        data_word_t res;
        res = old_w;
        for (int b = 0; b < BE_BITS; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic init_inputs();
        dir_match_i            <= 1'b0;
        dir_match_set_i        <= '0;
        dir_match_tag_i        <= '0;
        dir_update_lru_i       <= 1'b0;
        dir_refill_i           <= 1'b0;
        dir_refill_set_i       <= '0;
        dir_refill_way_i       <= '0;
        dir_refill_tag_i       <= '0;
        dir_refill_updt_plru_i <= 1'b0;
        dir_inval_check_i      <= 1'b0;
        dir_inval_nline_i      <= '0;
        dir_inval_write_i      <= 1'b0;
        data_read_i            <= 1'b0;
        data_read_set_i        <= '0;
        data_read_word_i       <= '0;
        data_write_i           <= 1'b0;
        data_write_set_i       <= '0;
        data_write_word_i      <= '0;
        data_write_way_i       <= '0;
        data_write_data_i      <= '0;
        data_write_be_i        <= '0;
        data_refill_i          <= 1'b0;
        data_refill_set_i      <= '0;
        data_refill_way_i      <= '0;
        data_refill_word_i     <= '0;
        data_refill_data_i     <= '0;
    endtask

    // Match with an optional read, LRU update in the hit cycle if asked
    task automatic lookup(input set_t set_idx, input tag_t tag, input logic rd,
                          input word_idx_t word, input logic updt);
        @(posedge clk_i);
        dir_update_lru_i <= 1'b0;
        dir_match_i      <= 1'b1;
        dir_match_set_i  <= set_idx;
        dir_match_tag_i  <= tag;
        data_read_i      <= rd;
        data_read_set_i  <= set_idx;
        data_read_word_i <= word;
        @(posedge clk_i);
        dir_match_i      <= 1'b0;
        data_read_i      <= 1'b0;
        dir_update_lru_i <= updt;
        @(negedge clk_i);
    endtask

    task automatic idle_cycle();
        @(posedge clk_i);
        dir_update_lru_i <= 1'b0;
        @(negedge clk_i);
    endtask

    task automatic refill_dir(input set_t set_idx, input way_vec_t way, input tag_t tag,
                              input logic updt);
        @(posedge clk_i);
        dir_refill_i           <= 1'b1;
        dir_refill_set_i       <= set_idx;
        dir_refill_way_i       <= way;
        dir_refill_tag_i       <= tag;
        dir_refill_updt_plru_i <= updt;
        @(posedge clk_i);
        dir_refill_i           <= 1'b0;
        dir_refill_updt_plru_i <= 1'b0;
    endtask

    task automatic refill_data(input set_t set_idx, input way_vec_t way, input word_idx_t word,
                               input data_word_t data);
        @(posedge clk_i);
        data_refill_i      <= 1'b1;
        data_refill_set_i  <= set_idx;
        data_refill_way_i  <= way;
        data_refill_word_i <= word;
        data_refill_data_i <= data;
        @(posedge clk_i);
        data_refill_i      <= 1'b0;
    endtask

    task automatic write_data(input set_t set_idx, input way_vec_t way, input word_idx_t word,
                              input data_word_t data, input be_t be);
        @(posedge clk_i);
        data_write_i      <= 1'b1;
        data_write_set_i  <= set_idx;
        data_write_way_i  <= way;
        data_write_word_i <= word;
        data_write_data_i <= data;
        data_write_be_i   <= be;
        @(posedge clk_i);
        data_write_i      <= 1'b0;
    endtask

    // Check, then an optional write in the very next cycle
    task automatic invalidate(input set_t set_idx, input tag_t tag, input logic wr,
                              output logic hit);
        nline_u nline;
        // Line number is the tag over the set
        nline.raw = {tag, set_idx};
        @(posedge clk_i);
        dir_inval_check_i <= 1'b1;
        dir_inval_nline_i <= nline;
        @(posedge clk_i);
        dir_inval_check_i <= 1'b0;
        dir_inval_write_i <= wr;
        @(negedge clk_i);
        hit = dir_inval_hit_o;
        @(posedge clk_i);
        dir_inval_write_i <= 1'b0;
    endtask

    task automatic init_and_empty_lookup();
        @(negedge clk_i);
        check_bit("ready_o", 1'b0, ready_o);
        check_way("dir_hit_way_o", '0, dir_hit_way_o);
        check_bit("dir_inval_hit_o", 1'b0, dir_inval_hit_o);
        @(posedge rst_ni);
        for (int i = 0; i < SETS; i++) begin
            @(negedge clk_i);
            check_bit("ready_o", 1'b0, ready_o);
        end
        @(negedge clk_i);
        check_bit("ready_o", 1'b1, ready_o);
        for (int s = 0; s < SETS; s++) begin
            lookup(set_t'(s), tag_t'($random(seed)), 1'b0, '0, 1'b0);
            check_way("dir_hit_way_o", '0, dir_hit_way_o);
        end
    endtask

    task automatic tag_refill_and_match();
        refill_dir(SET_A, WAY_2, TAG_A, 1'b0);
        lookup(SET_A, TAG_A, 1'b0, '0, 1'b0);
        check_way("dir_hit_way_o", WAY_2, dir_hit_way_o);
        lookup(SET_A, TAG_B, 1'b0, '0, 1'b0);
        check_way("dir_hit_way_o", '0, dir_hit_way_o);
    endtask

    task automatic line_refill_and_read();
        for (int w = 0; w < LINE_WORDS; w++) begin
            line_words[w] = $random(seed);
            refill_data(SET_A, WAY_2, word_idx_t'(w), line_words[w]);
        end
        for (int w = 0; w < LINE_WORDS; w++) begin
            lookup(SET_A, TAG_A, 1'b1, word_idx_t'(w), 1'b0);
            check_word("data_read_data_o", line_words[w], data_read_data_o);
        end
        lookup(SET_A, TAG_B, 1'b1, '0, 1'b0);
        check_way("dir_hit_way_o", '0, dir_hit_way_o);
        check_word("data_read_data_o", '0, data_read_data_o);
    endtask

    task automatic partial_byte_write();
        data_word_t new_word;
        new_word      = $random(seed);
        line_words[1] = merge_bytes(line_words[1], new_word, 4'b0011);
        write_data(SET_A, WAY_2, 2'd1, new_word, 4'b0011);
        lookup(SET_A, TAG_A, 1'b1, 2'd1, 1'b0);
        check_word("data_read_data_o", line_words[1], data_read_data_o);
    endtask

    task automatic line_invalidation();
        logic hit;
        invalidate(SET_A, TAG_B, 1'b0, hit);
        check_bit("dir_inval_hit_o", 1'b0, hit);
        invalidate(SET_A, TAG_A, 1'b1, hit);
        check_bit("dir_inval_hit_o", 1'b1, hit);
        lookup(SET_A, TAG_A, 1'b0, '0, 1'b0);
        check_way("dir_hit_way_o", '0, dir_hit_way_o);
    endtask

    task automatic victim_selection();
        logic hit;
        lookup(SET_V, 8'h10, 1'b0, '0, 1'b0);
        check_way("dir_victim_way_o", 4'b0001, dir_victim_way_o);
        for (int w = 0; w < WAYS; w++) begin
            refill_dir(SET_V, way_vec_t'(1 << w), tag_t'(8'h10 + w), 1'b1);
        end
        // LRU update rides in the hit cycle of way 0
        lookup(SET_V, 8'h10, 1'b0, '0, 1'b1);
        check_way("dir_hit_way_o", 4'b0001, dir_hit_way_o);
        check_way("dir_victim_way_o", 4'b0001, dir_victim_way_o);
        idle_cycle();
        check_way("dir_victim_way_o", 4'b0100, dir_victim_way_o);
        // Refill of way 2 turns the tree towards way 1
        refill_dir(SET_V, 4'b0100, 8'h12, 1'b1);
        @(negedge clk_i);
        check_way("dir_victim_way_o", 4'b0010, dir_victim_way_o);
        // An invalid way wins over the tree
        invalidate(SET_V, 8'h13, 1'b1, hit);
        check_bit("dir_inval_hit_o", 1'b1, hit);
        lookup(SET_V, 8'h10, 1'b0, '0, 1'b0);
        check_way("dir_victim_way_o", 4'b1000, dir_victim_way_o);
    endtask

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("checks=%0d errors=%0d", checks, errors);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : main
        seed   = 32'hbd10;
        checks = 0;
        errors = 0;
        init_inputs();
        init_and_empty_lookup();
        tag_refill_and_match();
        line_refill_and_read();
        partial_byte_write();
        line_invalidation();
        victim_selection();
        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
logic/cache_geom_pkg.sv
logic/cache_dir_pkg.sv
logic/sp_ram.sv
logic/dir_ctrl.sv
logic/plru_victim.sv
logic/data_ctrl.sv
logic/cache_memctrl.sv
test/clk_rst_gen.sv
test/tb_cache_memctrl.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cache memory controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cache_memctrl -f files.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qF -- "*** PASSED ***"; then
    exit 0
else
    exit 1
fi
